// File: all.f
design/adc_capture_pkg.sv
design/sample_downsampler.sv
design/sample_packer.sv
design/capture_controller.sv
design/line_fifo.sv
design/byte_serializer.sv
design/adc_capture_top.sv
bench/tb_adc_capture.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --timing --assert
TOP      := tb_adc_capture
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/tb_adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture;
	import adc_capture_pkg::*;

	localparam int MAX_CYCLES = 20000; // Whole run needs about 1500 cycles

	logic         adc_sampleclk;
	logic         fifo_rst;
	adc_sample_t  adc_data_i;     // Ramp, one step per cycle
	logic         capture_go_i;
	logic         arm_i;
	capture_cfg_t cfg_i;
	logic         byte_rd_i;
	logic         capture_stop_o;
	logic         overflow_o;
	data_byte_t   byte_o;
	logic         byte_empty_o;
	line_count_t  line_count_o;

	int           seed = 32'ha1c1_d435; // Ramp start values
	int           cycle_cnt;
	logic         reader_on;            // Host reader takes every byte shown
	logic [7:0]   got_q [$];            // Bytes taken from the DUT
	logic [7:0]   exp_q [$];            // Bytes predicted by the model

	adc_capture_top i_adc_capture_top (
		.adc_sampleclk  (adc_sampleclk),
		.fifo_rst       (fifo_rst),
		.adc_data_i     (adc_data_i),
		.capture_go_i   (capture_go_i),
		.arm_i          (arm_i),
		.cfg_i          (cfg_i),
		.byte_rd_i      (byte_rd_i),
		.capture_stop_o (capture_stop_o),
		.overflow_o     (overflow_o),
		.byte_o         (byte_o),
		.byte_empty_o   (byte_empty_o),
		.line_count_o   (line_count_o)
	);

	always #4 adc_sampleclk = ~adc_sampleclk; // 8 ns period

	// Hang guard
	always @(posedge adc_sampleclk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", MAX_CYCLES);
			$display("sim failed");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// One clock step; all inputs change 1 ns after the edge
	task automatic next_cycle;
		@(posedge adc_sampleclk);
		#1;
		adc_data_i = adc_data_i + 1'b1; // Ramp
		if (reader_on && !byte_empty_o) begin
			got_q.push_back(byte_o); // Consumed on the coming edge
			byte_rd_i = 1'b1;
		end else begin
			byte_rd_i = 1'b0;
		end
	endtask

	// Kept sample idx of a ramp from v0 with ds samples skipped between keeps
	function automatic adc_sample_t ramp_value(input adc_sample_t v0, input int ds,
			input int idx);
		return v0 + adc_sample_t'(idx * (ds + 1)); // Wraps at 10 bits like the ADC
	endfunction

	// Reference model of packer, line gathering and byte order
	task automatic predict_bytes(input adc_sample_t v0, input int ds, input int n_kept,
			input logic [1:0] tag);
		logic [31:0] word;
		adc_sample_t samp [3];
		int          n_words;
		int          w;
		int          s;
		int          b;
		n_words = (n_kept / (SAMPLES_PER_WORD * WORDS_PER_LINE)) * WORDS_PER_LINE; // Full lines only
		exp_q.delete();
		for (w = 0; w < n_words; w++) begin
			for (s = 0; s < 3; s++) begin
				samp[s] = ramp_value(v0, ds, 3 * w + s);
			end
			word = {tag, samp[2], samp[1], samp[0]}; // Tag on top, slot 0 low
			for (b = 0; b < 4; b++) begin
				exp_q.push_back(word[8*b +: 8]); // LSB first
			end
		end
	endtask

	task automatic compare_stream;
		int i;
		check_value("byte count", got_q.size(), exp_q.size());
		for (i = 0; i < exp_q.size(); i++) begin
			check_value($sformatf("byte_o, byte %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
		end
	endtask

	// Config, then arm edge; flush lands two cycles after it
	task automatic arm_capture(input logic stream, input int ds, input int max_s);
		cfg_i.stream_mode = stream;
		cfg_i.downsample  = ds_count_t'(ds);
		cfg_i.max_samples = sample_count_t'(max_s);
		arm_i = 1'b1;
		repeat (2) next_cycle();
		arm_i = 1'b0;
		repeat (4) next_cycle(); // Flush done, packer back at slot 0
	endtask

	task automatic start_capture(output adc_sample_t v0);
		v0           = adc_sample_t'($random(seed));
		adc_data_i   = v0;   // First kept sample
		capture_go_i = 1'b1;
	endtask

	// Normal mode run to stop, then drain the bytes with capture_go_i low
	task automatic run_normal_capture(input int ds, input int max_s, output adc_sample_t v0);
		int n_bytes;
		arm_capture(1'b0, ds, max_s);
		got_q.delete();
		reader_on = 1'b1;
		start_capture(v0);
		while (!capture_stop_o) begin
			next_cycle();
		end
		check_value("byte count while capture_go_i high", got_q.size(), 0); // Reads blocked
		capture_go_i = 1'b0;
		n_bytes = (max_s / (SAMPLES_PER_WORD * WORDS_PER_LINE)) * BYTES_PER_LINE;
		while (got_q.size() < n_bytes) begin
			next_cycle();
		end
		repeat (20) next_cycle(); // Room for any stray extra byte
		reader_on = 1'b0;
		check_value("byte count", got_q.size(), n_bytes);
		check_value("byte_empty_o", 32'(byte_empty_o), 32'd1);
	endtask

	task automatic reset_state_test;
		check_value("byte_empty_o", 32'(byte_empty_o), 32'd1);
		check_value("capture_stop_o", 32'(capture_stop_o), 32'd0);
		check_value("overflow_o", 32'(overflow_o), 32'd0);
	endtask

	task automatic normal_capture_test;
		adc_sample_t v0;
		run_normal_capture(0, 12, v0); // One line of four words
		predict_bytes(v0, 0, 12, 2'd0);
		compare_stream();
	endtask

	// Decode words back into samples
	task automatic downsampled_capture_test;
		adc_sample_t v0;
		logic [31:0] word;
		int          w;
		int          s;
		run_normal_capture(2, 12, v0); // Every third ramp value
		for (w = 0; w < got_q.size() / 4; w++) begin
			word = {got_q[4*w+3], got_q[4*w+2], got_q[4*w+1], got_q[4*w]};
			check_value($sformatf("tag of word %0d", w), 32'(word[31:30]), 32'd0);
			for (s = 0; s < 3; s++) begin
				check_value($sformatf("sample %0d", 3 * w + s), 32'(word[10*s +: 10]),
					32'(ramp_value(v0, 2, 3 * w + s)));
			end
		end
	endtask

	task automatic stream_read_test;
		adc_sample_t v0;
		int          n_during;
		arm_capture(1'b1, 0, 0);
		got_q.delete();
		reader_on = 1'b1;
		start_capture(v0);
		repeat (36) next_cycle(); // 36 samples, three lines
		n_during = got_q.size();
		check_value("bytes read during capture", 32'(n_during > 0), 32'd1);
		capture_go_i = 1'b0;
		predict_bytes(v0, 0, 36, 2'd0);
		while (got_q.size() < exp_q.size()) begin
			next_cycle();
		end
		repeat (20) next_cycle();
		reader_on = 1'b0;
		compare_stream();
	endtask

	task automatic stream_overflow_test;
		adc_sample_t v0;
		arm_capture(1'b1, 0, 0);
		reader_on = 1'b0;
		start_capture(v0);
		while (!capture_stop_o) begin
			next_cycle(); // FIFO fills with nobody reading
		end
		check_value("overflow_o", 32'(overflow_o), 32'd1);
		capture_go_i = 1'b0;
		arm_capture(1'b1, 0, 0); // Arm clears everything
		check_value("overflow_o", 32'(overflow_o), 32'd0);
		check_value("capture_stop_o", 32'(capture_stop_o), 32'd0);
		check_value("byte_empty_o", 32'(byte_empty_o), 32'd1);
		check_value("line_count_o", 32'(line_count_o), 32'd0);
	endtask

	// History is bounded; one line above the limit lives for a single cycle
	task automatic drain_history_test;
		adc_sample_t v0;
		int          peak;
		arm_capture(1'b0, 0, 100000);
		reader_on = 1'b0;
		peak      = 0;
		start_capture(v0);
		repeat (600) begin // About 50 lines written
			next_cycle();
			if (int'(line_count_o) > peak) begin
				peak = int'(line_count_o);
			end
		end
		check_value("capture_stop_o", 32'(capture_stop_o), 32'd0);
		check_value("line_count_o peak", peak, FIFO_DRAIN_LINES + 1);
		capture_go_i = 1'b0;
		next_cycle();
	endtask

	initial begin
		adc_sampleclk = 1'b0;
		fifo_rst      = 1'b1;
		adc_data_i    = '0;
		capture_go_i  = 1'b0;
		arm_i         = 1'b0;
		cfg_i         = '0;
		byte_rd_i     = 1'b0;
		reader_on     = 1'b0;
		cycle_cnt     = 0;
		repeat (16) next_cycle(); // Reset held 16 cycles
		fifo_rst = 1'b0;
		next_cycle();
		reset_state_test();
		normal_capture_test();
		downsampled_capture_test();
		stream_read_test();
		stream_overflow_test();
		drain_history_test();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top (
	input  wire                                adc_sampleclk,
	input  wire                                fifo_rst,
	input  wire adc_capture_pkg::adc_sample_t  adc_data_i,
	input  wire                                capture_go_i, // Held until capture_stop_o
	input  wire                                arm_i,
	input  wire adc_capture_pkg::capture_cfg_t cfg_i,
	input  wire                                byte_rd_i,
	output wire                                capture_stop_o,
	output wire                                overflow_o,
	output wire adc_capture_pkg::data_byte_t   byte_o,
	output wire                                byte_empty_o,
	output wire adc_capture_pkg::line_count_t  line_count_o
);
	import adc_capture_pkg::*;

	logic         keep_stb;    // Downsampler keep strobe
	adc_sample_t  keep_data;   // Kept sample
	logic         word_wr;     // Packed word write
	packed_word_t word_data;
	logic         flush;       // Arm flush
	logic         capture_en;
	logic         drain;       // Drop oldest line
	logic         rd_allow;
	logic         line_valid;  // FIFO head available
	fifo_line_t   line_data;
	logic         line_pop;
	logic         wr_overflow; // Word dropped on full
	line_count_t  line_count;

	assign line_count_o = line_count;

	sample_downsampler i_sample_downsampler (
		.adc_sampleclk (adc_sampleclk),
		.fifo_rst      (fifo_rst),
		.capture_go_i  (capture_go_i),
		.downsample_i  (cfg_i.downsample),
		.adc_data_i    (adc_data_i),
		.keep_stb_o    (keep_stb),
		.keep_data_o   (keep_data)
	);

	sample_packer i_sample_packer (
		.adc_sampleclk (adc_sampleclk),
		.fifo_rst      (fifo_rst),
		.flush_i       (flush),
		.capture_go_i  (capture_go_i),
		.capture_en_i  (capture_en),
		.keep_stb_i    (keep_stb),
		.keep_data_i   (keep_data),
		.word_wr_o     (word_wr),
		.word_data_o   (word_data)
	);

	capture_controller i_capture_controller (
		.adc_sampleclk  (adc_sampleclk),
		.fifo_rst       (fifo_rst),
		.arm_i          (arm_i),
		.capture_go_i   (capture_go_i),
		.keep_stb_i     (keep_stb),
		.cfg_i          (cfg_i),
		.wr_overflow_i  (wr_overflow),
		.line_count_i   (line_count),
		.flush_o        (flush),
		.capture_en_o   (capture_en),
		.capture_stop_o (capture_stop_o),
		.drain_o        (drain),
		.rd_allow_o     (rd_allow),
		.overflow_o     (overflow_o)
	);

	line_fifo i_line_fifo (
		.adc_sampleclk (adc_sampleclk),
		.fifo_rst      (fifo_rst),
		.flush_i       (flush),
		.word_wr_i     (word_wr),
		.word_data_i   (word_data),
		.drain_i       (drain),
		.line_pop_i    (line_pop),
		.line_valid_o  (line_valid),
		.line_data_o   (line_data),
		.line_count_o  (line_count),
		.wr_overflow_o (wr_overflow)
	);

	byte_serializer i_byte_serializer (
		.adc_sampleclk (adc_sampleclk),
		.fifo_rst      (fifo_rst),
		.flush_i       (flush),
		.rd_allow_i    (rd_allow),
		.line_valid_i  (line_valid),
		.line_data_i   (line_data),
		.line_pop_o    (line_pop),
		.byte_rd_i     (byte_rd_i),
		.byte_o        (byte_o),
		.byte_empty_o  (byte_empty_o)
	);

endmodule

`default_nettype wire

// File: design/byte_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_serializer (
	input  wire                                adc_sampleclk,
	input  wire                                fifo_rst,
	input  wire                                flush_i,
	input  wire                                rd_allow_i,
	input  wire                                line_valid_i,
	input  wire adc_capture_pkg::fifo_line_t   line_data_i,
	output logic                               line_pop_o,
	input  wire                                byte_rd_i,
	output adc_capture_pkg::data_byte_t        byte_o,
	output logic                               byte_empty_o
);
	import adc_capture_pkg::*;

	fifo_line_t hold_line; // Line being read out
	logic [3:0] byte_idx;  // Byte shown, LSB first
	logic       full;      // Holding register in use
	logic       last_byte; // Final byte of the line shown

	assign last_byte  = (byte_idx == 4'(BYTES_PER_LINE - 1));
	assign line_pop_o = rd_allow_i && line_valid_i && !full && !flush_i; // Refill when used up

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_i) begin
			full     <= 1'b0;
			byte_idx <= '0;
		end else if (line_pop_o) begin
			full     <= 1'b1;
			byte_idx <= '0;
		end else if (full && byte_rd_i) begin
			if (last_byte) begin
				full     <= 1'b0; // Line consumed
				byte_idx <= '0;
			end else begin
				byte_idx <= byte_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (line_pop_o) begin
			hold_line <= line_data_i;
		end
	end

	assign byte_o       = hold_line[{byte_idx, 3'b000} +: 8];
	assign byte_empty_o = !full; // Reads while empty fall through

	// A pop fills the holder, so back-to-back pops never happen
	pop_into_empty: assert property (@(posedge adc_sampleclk)
		disable iff (fifo_rst || flush_i)
		line_pop_o |=> !line_pop_o)
		else $error("line popped into a full holding register");

endmodule

`default_nettype wire

// File: design/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo (
	input  wire                                adc_sampleclk,
	input  wire                                fifo_rst,
	input  wire                                flush_i,
	input  wire                                word_wr_i,
	input  wire adc_capture_pkg::packed_word_t word_data_i,
	input  wire                                drain_i,
	input  wire                                line_pop_i,
	output logic                               line_valid_o,
	output adc_capture_pkg::fifo_line_t        line_data_o,
	output adc_capture_pkg::line_count_t       line_count_o,
	output logic                               wr_overflow_o
);
	import adc_capture_pkg::*;

	fifo_line_t                        mem [FIFO_LINES]; // Line storage
	packed_word_t [WORDS_PER_LINE-2:0] asm_words;        // Words of the open line
	logic [1:0]                        word_idx;         // Next word position
	fifo_ptr_t                         wr_ptr;
	fifo_ptr_t                         rd_ptr;
	line_count_t                       count;            // Complete lines held
	logic                              full;
	logic                              remove;           // Head line leaves
	logic                              word_ok;          // Word accepted
	logic                              line_push;        // Fourth word closes line

	assign full      = (count == line_count_t'(FIFO_LINES));
	assign remove    = line_valid_o && (line_pop_i || drain_i); // Pop plus drain is one line
	assign word_ok   = word_wr_i && (!full || remove);
	assign line_push = word_ok && (word_idx == 2'(WORDS_PER_LINE - 1));

	assign wr_overflow_o = word_wr_i && !word_ok; // Dropped word

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_i) begin
			word_idx <= '0; // Partial line discarded
		end else if (word_ok) begin
			word_idx <= line_push ? '0 : word_idx + 1'b1;
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (word_ok && !line_push) begin
			asm_words[word_idx] <= word_data_i;
		end
	end

	// Last word goes straight in with the three gathered ones
	always_ff @(posedge adc_sampleclk) begin
		if (line_push) begin
			mem[wr_ptr] <= {word_data_i, asm_words};
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (line_push) begin
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			end
			if (remove) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({line_push, remove})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head line falls through
	assign line_valid_o = (count != '0);
	assign line_data_o  = mem[rd_ptr];
	assign line_count_o = count;

	count_bounded: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
		count <= line_count_t'(FIFO_LINES))
		else $error("line count above FIFO depth");

endmodule

`default_nettype wire

// File: design/capture_controller.sv
`timescale 1ns/1ps
`default_nettype none

module capture_controller (
	input  wire                                adc_sampleclk,
	input  wire                                fifo_rst,
	input  wire                                arm_i,
	input  wire                                capture_go_i,
	input  wire                                keep_stb_i,
	input  wire adc_capture_pkg::capture_cfg_t cfg_i,
	input  wire                                wr_overflow_i,
	input  wire adc_capture_pkg::line_count_t  line_count_i,
	output logic                               flush_o,
	output logic                               capture_en_o,
	output logic                               capture_stop_o,
	output logic                               drain_o,
	output logic                               rd_allow_o,
	output logic                               overflow_o
);
	import adc_capture_pkg::*;

	logic          arm_q1;    // Arm, first stage
	logic          arm_q2;    // Arm, second stage
	sample_count_t kept_cnt;  // Kept samples this capture
	logic          cnt_done;  // Max samples reached
	logic          stop_set;  // Normal mode stop condition
	logic          stop_q;    // Registered normal mode stop
	logic          stop_next; // Stop as seen after this edge

	// Arm rising edge turns into a one-cycle flush
	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst) begin
			arm_q1  <= 1'b0;
			arm_q2  <= 1'b0;
			flush_o <= 1'b0;
		end else begin
			arm_q1  <= arm_i;
			arm_q2  <= arm_q1;
			flush_o <= arm_q1 && !arm_q2;
		end
	end

	assign cnt_done = (kept_cnt == cfg_i.max_samples);
	assign stop_set = capture_go_i && !cfg_i.stream_mode && cnt_done;

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || !capture_go_i) begin
			kept_cnt <= '0; // Restart with every capture
		end else if (keep_stb_i && !cnt_done) begin
			kept_cnt <= kept_cnt + 1'b1; // Hold at max
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst) begin
			stop_q <= 1'b0;
		end else begin
			stop_q <= stop_set;
		end
	end

	// Sticky until the next arm
	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_o) begin
			overflow_o <= 1'b0;
		end else if (wr_overflow_i) begin
			overflow_o <= 1'b1;
		end
	end

	assign stop_next = cfg_i.stream_mode ? (overflow_o || wr_overflow_i) : stop_set;

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_o) begin
			capture_en_o <= 1'b1; // Rearmed
		end else if (stop_next) begin
			capture_en_o <= 1'b0; // Falls together with stop
		end
	end

	assign capture_stop_o = cfg_i.stream_mode ? overflow_o : stop_q;
	assign drain_o        = !cfg_i.stream_mode && (line_count_i > line_count_t'(FIFO_DRAIN_LINES));
	assign rd_allow_o     = cfg_i.stream_mode || !capture_go_i; // Normal mode reads after capture

	en_rise_needs_flush: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
		$rose(capture_en_o) |-> ($past(flush_o) || $past(fifo_rst)))
		else $error("capture enable rose without flush");

endmodule

`default_nettype wire

// File: design/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_packer (
	input  wire                                adc_sampleclk,
	input  wire                                fifo_rst,
	input  wire                                flush_i,
	input  wire                                capture_go_i,
	input  wire                                capture_en_i,
	input  wire                                keep_stb_i,
	input  wire adc_capture_pkg::adc_sample_t  keep_data_i,
	output logic                               word_wr_o,
	output adc_capture_pkg::packed_word_t      word_data_o
);
	import adc_capture_pkg::*;

	adc_sample_t samp0;     // Slot 0 holding register
	adc_sample_t samp1;     // Slot 1 holding register
	adc_sample_t samp2;     // Slot 2 holding register
	slot_idx_t   slot;      // Slot the next kept sample lands in
	slot_idx_t   start_tag; // Slot at capture start
	logic        go_q;      // Capture go, one cycle late
	logic        slot_last; // Current slot completes a word

	assign slot_last = (slot == slot_idx_t'(SAMPLES_PER_WORD - 1));

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_i) begin
			slot <= '0;
		end else if (keep_stb_i) begin
			slot <= slot_last ? '0 : slot + 1'b1; // Walk 0, 1, 2
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (keep_stb_i) begin
			case (slot)
				2'd0:    samp0 <= keep_data_i;
				2'd1:    samp1 <= keep_data_i;
				default: samp2 <= keep_data_i;
			endcase
		end
	end

	// Tag marks where the capture started inside the word
	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst) begin
			go_q      <= 1'b0;
			start_tag <= '0;
		end else begin
			go_q <= capture_go_i;
			if (capture_go_i && !go_q) begin
				start_tag <= slot; // First cycle of capture
			end
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || flush_i) begin
			word_wr_o <= 1'b0;
		end else begin
			word_wr_o <= keep_stb_i && slot_last && capture_en_i; // Word full next cycle
		end
	end

	always_comb begin
		word_data_o.tag   = start_tag;
		word_data_o.slot2 = samp2;
		word_data_o.slot1 = samp1;
		word_data_o.slot0 = samp0;
	end

	slot_in_range: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
		slot != 2'd3)
		else $error("packer slot reached 3");

endmodule

`default_nettype wire

// File: design/sample_downsampler.sv
`timescale 1ns/1ps
`default_nettype none

module sample_downsampler (
	input  wire                                adc_sampleclk,
	input  wire                                fifo_rst,
	input  wire                                capture_go_i,
	input  wire adc_capture_pkg::ds_count_t    downsample_i,
	input  wire adc_capture_pkg::adc_sample_t  adc_data_i,
	output logic                               keep_stb_o,
	output adc_capture_pkg::adc_sample_t       keep_data_o
);
	import adc_capture_pkg::*;

	ds_count_t ds_cnt;  // Samples seen since last keep
	logic      ds_hit;  // Counter at the wrap point
	logic      ds_keep; // Counter at a kept sample

	assign ds_hit  = (ds_cnt == downsample_i);
	assign ds_keep = (ds_cnt == '0);

	// Plain skip counter, no filtering
	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst || !capture_go_i) begin
			ds_cnt <= '0; // Sample 0 of a capture is always kept
		end else if (ds_hit) begin
			ds_cnt <= '0;
		end else begin
			ds_cnt <= ds_cnt + 1'b1;
		end
	end

	always_ff @(posedge adc_sampleclk) begin
		if (fifo_rst) begin
			keep_stb_o <= 1'b0;
		end else begin
			keep_stb_o <= capture_go_i && ds_keep; // Nothing kept outside capture
		end
	end

	// Sample registered alongside the strobe
	always_ff @(posedge adc_sampleclk) begin
		keep_data_o <= adc_data_i;
	end

endmodule

`default_nettype wire

// File: design/adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

	// Datapath geometry
	localparam int ADC_BITS         = 10; // ADC resolution
	localparam int SAMPLES_PER_WORD = 3;  // Samples merged into one word
	localparam int WORDS_PER_LINE   = 4;  // Words gathered into one line
	localparam int BYTES_PER_LINE   = 16; // Bytes handed out per line

	// FIFO sizing
	localparam int FIFO_LINES       = 32; // Depth in lines
	localparam int FIFO_DRAIN_LINES = 24; // Pre-capture history limit
	localparam int FIFO_PTR_W       = $clog2(FIFO_LINES);

	typedef logic [ADC_BITS-1:0]   adc_sample_t;   // One raw ADC sample
	typedef logic [1:0]            slot_idx_t;     // Packer slot
	typedef logic [12:0]           ds_count_t;     // Downsample skip count
	typedef logic [31:0]           sample_count_t; // Kept samples
	typedef logic [7:0]            line_count_t;   // Lines held in FIFO
	typedef logic [7:0]            data_byte_t;    // Host read byte
	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;     // Line memory address

	// Three samples plus the slot that was current at capture start
	typedef struct packed {
		slot_idx_t   tag;   // Bits 31:30
		adc_sample_t slot2; // Bits 29:20
		adc_sample_t slot1; // Bits 19:10
		adc_sample_t slot0; // Bits 9:0
	} packed_word_t;

	// First written word sits in the low 32 bits
	typedef logic [WORDS_PER_LINE*$bits(packed_word_t)-1:0] fifo_line_t;

	// Quasi-static capture setup, held stable during a capture
	typedef struct packed {
		ds_count_t     downsample;  // Samples skipped between keeps
		sample_count_t max_samples; // Normal mode stop point
		logic          stream_mode; // 1 = stream, 0 = normal
	} capture_cfg_t;

endpackage

`default_nettype wire
